/* rtl/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Primary opcodes.
`define OP_RTYPE 6'b000000
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_ADDI  6'b001000
`define OP_ADDIU 6'b001001
`define OP_SLTI  6'b001010
`define OP_SLTIU 6'b001011
`define OP_ORI   6'b001101
`define OP_XORI  6'b001110
`define OP_LUI   6'b001111
`define OP_LW    6'b100011
`define OP_SW    6'b101011

// Function codes for R-type.
`define FN_SLL   6'b000000
`define FN_SRL   6'b000010
`define FN_SRA   6'b000011
`define FN_ADDU  6'b100001
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_XOR   6'b100110
`define FN_NOR   6'b100111
`define FN_SLT   6'b101010
`define FN_SLTU  6'b101011

`define DMEM_WORDS 256

`endif

/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same word, seen as R-type or as I-type.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,
        ALU_AND    = 4'b0010,
        ALU_OR     = 4'b0011,
        ALU_NOR    = 4'b0100,
        ALU_XOR    = 4'b0101,
        ALU_SLL    = 4'b0110,
        ALU_SRA    = 4'b0111,
        ALU_SRL    = 4'b1000,
        ALU_SLT    = 4'b1001,
        ALU_SLTU   = 4'b1010,
        ALU_BCMP   = 4'b1110, // Branch compare, done as sub.
        ALU_PASS_B = 4'b1111
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    alu_shamt;
        logic    alu_imm;
        alu_op_e alu_op;
        logic    mem_to_reg;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic [31:0] next_pc;
    } retire_t;

endpackage

`default_nettype wire

/* rtl/decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module decode
    import mips_pkg::*;
(
    input  instr_u      instr,
    input  logic [31:0] pc,
    output ctrl_t       ctrl,
    output logic [4:0]  rs,
    output logic [4:0]  rt,
    output logic [4:0]  rd_sel,
    output logic [4:0]  shamt,
    output logic [31:0] imm
);

    logic        sign_ext;
    logic [1:0]  imm_type; // 00 ext, 01 ext<<16, 10 ext<<2, 11 pc+4.
    logic [1:0]  reg_dst;  // 00 none, 01 rd, 10 rt, 11 r31.
    logic [31:0] ext_imm;

    // Fields: sign, imm_type, reg_dst, then ctrl_t from reg_write down to jump.
    always_comb begin
        {sign_ext, imm_type, reg_dst, ctrl} = '0;
        if (instr.r.op == `OP_RTYPE) begin
            case (instr.r.funct)
                `FN_ADDU: {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_0_0_0000_0_0_0_0_0;
                `FN_SUBU: {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_0_0_0001_0_0_0_0_0;
                `FN_AND:  {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_0_0_0010_0_0_0_0_0;
                `FN_OR:   {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_0_0_0011_0_0_0_0_0;
                `FN_NOR:  {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_0_0_0100_0_0_0_0_0;
                `FN_XOR:  {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_0_0_0101_0_0_0_0_0;
                `FN_SLL:  {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_1_0_0110_0_0_0_0_0;
                `FN_SRA:  {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_1_0_0111_0_0_0_0_0;
                `FN_SRL:  {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_1_0_1000_0_0_0_0_0;
                `FN_SLT:  {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_0_0_1001_0_0_0_0_0;
                `FN_SLTU: {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_01_1_0_0_1010_0_0_0_0_0;
                default:  {sign_ext, imm_type, reg_dst, ctrl} = '0;
            endcase
        end else begin
            case (instr.i.op)
                `OP_ADDIU: {sign_ext, imm_type, reg_dst, ctrl} = 17'b1_00_10_1_0_1_0000_0_0_0_0_0;
                `OP_ADDI:  {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_10_1_0_1_0000_0_0_0_0_0;
                `OP_ORI:   {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_10_1_0_1_0011_0_0_0_0_0;
                `OP_XORI:  {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_10_1_0_1_0101_0_0_0_0_0;
                `OP_SLTI:  {sign_ext, imm_type, reg_dst, ctrl} = 17'b1_00_10_1_0_1_1001_0_0_0_0_0;
                `OP_SLTIU: {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_10_1_0_1_1010_0_0_0_0_0;
                `OP_LUI:   {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_01_10_1_0_1_1111_0_0_0_0_0;
                `OP_BEQ:   {sign_ext, imm_type, reg_dst, ctrl} = 17'b1_10_00_0_0_1_1110_0_0_1_0_0;
                `OP_BNE:   {sign_ext, imm_type, reg_dst, ctrl} = 17'b1_10_00_0_0_1_1110_0_0_0_1_0;
                `OP_LW:    {sign_ext, imm_type, reg_dst, ctrl} = 17'b1_00_10_1_0_1_0000_1_0_0_0_0;
                `OP_SW:    {sign_ext, imm_type, reg_dst, ctrl} = 17'b1_00_00_0_0_1_0000_0_1_0_0_0;
                `OP_J:     {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_00_00_0_0_0_0000_0_0_0_0_1;
                `OP_JAL:   {sign_ext, imm_type, reg_dst, ctrl} = 17'b0_11_11_1_0_1_1111_0_0_0_0_1;
                default:   {sign_ext, imm_type, reg_dst, ctrl} = '0;
            endcase
        end
    end

    assign rs    = instr.i.rs;
    assign rt    = instr.i.rt;
    assign shamt = instr.r.shamt;

    always_comb begin
        case (reg_dst)
            2'b01:   rd_sel = instr.r.rd;
            2'b10:   rd_sel = instr.i.rt;
            2'b11:   rd_sel = 5'd31; // Link register.
            default: rd_sel = 5'd0;
        endcase
    end

    assign ext_imm = sign_ext ? {{16{instr.i.imm[15]}}, instr.i.imm} : {16'b0, instr.i.imm};

    always_comb begin
        case (imm_type)
            2'b01:   imm = ext_imm << 16;
            2'b10:   imm = ext_imm << 2;  // Branch offset in bytes.
            2'b11:   imm = pc + 32'd4;    // Return address for JAL.
            default: imm = ext_imm;
        endcase
    end

    a_one_flow: assert final ($onehot0({ctrl.branch_eq, ctrl.branch_ne, ctrl.jump}))
        else $error("decode: more than one flow control set");

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
    import mips_pkg::*;
(
    input  alu_op_e     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [4:0]  shamt,
    input  logic        use_shamt,
    output logic [31:0] y
);

    logic [4:0] sh;

    // Variable shifts take their amount from rs.
    assign sh = use_shamt ? shamt : a[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    y = a + b;
            ALU_SUB,
            ALU_BCMP:   y = a - b;
            ALU_AND:    y = a & b;
            ALU_OR:     y = a | b;
            ALU_NOR:    y = ~(a | b);
            ALU_XOR:    y = a ^ b;
            ALU_SLL:    y = b << sh;
            ALU_SRA:    y = $signed(b) >>> sh;
            ALU_SRL:    y = b >> sh;
            ALU_SLT:    y = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   y = {31'b0, a < b};
            ALU_PASS_B: y = b; // LUI and JAL.
            default:    y = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd; // Register 0 stays zero.
        end
    end

    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

    a_wd_known: assert property (@(posedge clk) disable iff (!arst_n) we |-> !$isunknown(wd))
        else $error("reg_file: unknown write data");

endmodule

`default_nettype wire

/* rtl/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  instr_u      instr,
    input  ctrl_t       ctrl,
    input  logic [31:0] rs_val,
    input  logic [31:0] rt_val,
    input  logic [31:0] imm,
    output logic [31:0] pc,
    output logic [31:0] next_pc
);

    logic [31:0] pc_plus4;
    logic [31:0] jump_target;
    logic        taken;

    assign pc_plus4 = pc + 32'd4;
    assign taken    = (ctrl.branch_eq && rs_val == rt_val) ||
                      (ctrl.branch_ne && rs_val != rt_val);

    // J target spans rs, rt and imm of the I view.
    assign jump_target = {pc_plus4[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};

    always_comb begin
        if (ctrl.jump) begin
            next_pc = jump_target;
        end else if (taken) begin
            next_pc = pc_plus4 + imm; // No delay slot.
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else $error("branch_unit: pc not word aligned");

endmodule

`default_nettype wire

/* rtl/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module data_mem (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        we,
    output logic [31:0] rdata
);

    logic [31:0]                     mem [`DMEM_WORDS];
    logic [$clog2(`DMEM_WORDS)-1:0]  idx;

    assign idx = addr[$clog2(`DMEM_WORDS)+1:2]; // Word index.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

    a_store_addr: assert property (@(posedge clk) disable iff (!arst_n)
        we |-> (addr[1:0] == 2'b00 && addr[31:2] < `DMEM_WORDS))
        else $error("data_mem: store address 0x%08h misaligned or out of range", addr);

endmodule

`default_nettype wire

/* rtl/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output retire_t     retire
);

    instr_u      instr_w;
    ctrl_t       ctrl;
    logic [4:0]  rs_idx;
    logic [4:0]  rt_idx;
    logic [4:0]  rd_sel;
    logic [4:0]  shamt;
    logic [31:0] imm;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic [31:0] mem_rdata;
    logic [31:0] wb_data;
    logic [31:0] next_pc;

    assign instr_w = instr;

    decode u_decode (
        .instr  (instr_w),
        .pc     (pc),
        .ctrl   (ctrl),
        .rs     (rs_idx),
        .rt     (rt_idx),
        .rd_sel (rd_sel),
        .shamt  (shamt),
        .imm    (imm)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (rs_idx),
        .ra2    (rt_idx),
        .wa     (rd_sel),
        .we     (ctrl.reg_write),
        .wd     (wb_data),
        .rd1    (rs_val),
        .rd2    (rt_val)
    );

    assign alu_b = ctrl.alu_imm ? imm : rt_val;

    alu u_alu (
        .op        (ctrl.alu_op),
        .a         (rs_val),
        .b         (alu_b),
        .shamt     (shamt),
        .use_shamt (ctrl.alu_shamt),
        .y         (alu_y)
    );

    data_mem u_data_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (alu_y),
        .wdata  (rt_val),
        .we     (ctrl.mem_write),
        .rdata  (mem_rdata)
    );

    assign wb_data = ctrl.mem_to_reg ? mem_rdata : alu_y;

    branch_unit u_branch_unit (
        .clk     (clk),
        .arst_n  (arst_n),
        .instr   (instr_w),
        .ctrl    (ctrl),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .imm     (imm),
        .pc      (pc),
        .next_pc (next_pc)
    );

    // Record lands on the same edge as the writes and the pc update.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire <= '0;
        end else begin
            retire.we      <= ctrl.reg_write;
            retire.waddr   <= rd_sel;
            retire.wdata   <= wb_data;
            retire.next_pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* verification/tb_mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core
    import mips_pkg::*;
();

    localparam int          MAX_LINES    = 64;
    localparam int          TIMEOUT      = 200;
    localparam logic [31:0] SKIP_NEXT_PC = 32'hffff_ffff;

    logic        clk;
    logic        arst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    retire_t     retire;

    logic [31:0] prog_instr [MAX_LINES];
    retire_t     prog_exp   [MAX_LINES];
    int          num_lines;
    int          errors;
    int          timeouts;

    mips_core u_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .instr  (instr),
        .pc     (pc),
        .retire (retire)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic load_tests();
        integer      fd;
        string       line;
        int          n;
        logic [31:0] word;
        logic [31:0] we_v;
        logic [31:0] wa_v;
        logic [31:0] wd_v;
        logic [31:0] np_v;
        num_lines = 0;
        fd = $fopen("verification/mips_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/mips_tests.txt.");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h", word, we_v, wa_v, wd_v, np_v);
            if (line.len() > 0 && line[0] != "#" && n == 5) begin
                if (num_lines < MAX_LINES) begin
                    prog_instr[num_lines]       = word;
                    prog_exp[num_lines].we      = we_v[0];
                    prog_exp[num_lines].waddr   = wa_v[4:0];
                    prog_exp[num_lines].wdata   = wd_v;
                    prog_exp[num_lines].next_pc = np_v;
                    num_lines++;
                end else begin
                    $display("Tests file has more lines than the program memory holds.");
                    errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Address and data only matter when the record writes a register.
    task automatic check_retire(input retire_t act, input retire_t exp);
        if (act.we !== exp.we) begin
            $display("Fail at %0d ns: retire.we expected %0b, got %0b", $time, exp.we, act.we);
            errors++;
        end
        if (exp.we && act.waddr !== exp.waddr) begin
            $display("Fail at %0d ns: retire.waddr expected %0d, got %0d",
                     $time, exp.waddr, act.waddr);
            errors++;
        end
        if (exp.we && act.wdata !== exp.wdata) begin
            $display("Fail at %0d ns: retire.wdata expected %08h, got %08h",
                     $time, exp.wdata, act.wdata);
            errors++;
        end
        if (act.next_pc !== exp.next_pc) begin
            $display("Fail at %0d ns: retire.next_pc expected %08h, got %08h",
                     $time, exp.next_pc, act.next_pc);
            errors++;
        end
    endtask

    task automatic check_pc(input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("Fail at %0d ns: pc expected %08h, got %08h", $time, exp, act);
            errors++;
        end
    endtask

    initial begin
        int          cycles;
        int          idx;
        logic        done;
        logic [31:0] last_addr;
        arst_n   = 1'b0;
        instr    = '0;
        errors   = 0;
        timeouts = 0;
        load_tests();
        last_addr = 32'((num_lines - 1) * 4); // Final line is the self jump.

        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        cycles = 0;
        while ($isunknown({pc, retire}) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if ($isunknown({pc, retire})) begin
            $display("Timed out waiting for the core to leave reset with known outputs.");
            timeouts++;
        end

        // Nothing has executed yet.
        check_pc(pc, 32'd0);
        check_retire(retire, '0);

        done   = (num_lines == 0);
        cycles = 0;
        idx    = 0;
        instr  = prog_instr[0];
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            check_retire(retire, prog_exp[idx]);
            check_pc(pc, prog_exp[idx].next_pc);
            if (pc === last_addr) begin
                done = 1'b1;
            end else if ($isunknown(pc) || pc[31:2] >= 30'(num_lines)) begin
                $display("pc %08h points outside the test program.", pc);
                errors++;
                done = 1'b1;
            end else begin
                idx = int'(pc[31:2]);
                if (prog_exp[idx].next_pc == SKIP_NEXT_PC) begin
                    $display("Line %0d was fetched although a branch or jump skips it.", idx);
                    errors++;
                    done = 1'b1;
                end else begin
                    instr = prog_instr[idx];
                end
            end
        end
        if (!done) begin
            $display("Timed out before the program reached its final jump.");
            timeouts++;
        end

        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/mips_tests.txt */
# instr    we waddr wdata    next_pc, all hex, one line per word address from 0.
# next_pc ffffffff marks a line that a branch or jump must skip.
2401fffb 1 01 fffffffb 00000004  # addiu r1, r0, -5
34028001 1 02 00008001 00000008  # ori   r2, r0, 0x8001
3c031234 1 03 12340000 0000000c  # lui   r3, 0x1234
00222021 1 04 00007ffc 00000010  # addu  r4, r1, r2
00412823 1 05 00008006 00000014  # subu  r5, r2, r1
00233024 1 06 12340000 00000018  # and   r6, r1, r3
00223827 1 07 00000004 0000001c  # nor   r7, r1, r2
00434026 1 08 12348001 00000020  # xor   r8, r2, r3
00014883 1 09 fffffffe 00000024  # sra   r9, r1, 2
00015102 1 0a 0fffffff 00000028  # srl   r10, r1, 4
00025a00 1 0b 00800100 0000002c  # sll   r11, r2, 8
0022602a 1 0c 00000001 00000030  # slt   r12, r1, r2
0022682b 1 0d 00000000 00000034  # sltu  r13, r1, r2
24000007 1 00 00000007 00000038  # addiu r0, r0, 7
00007021 1 0e 00000000 0000003c  # addu  r14, r0, r0
ac080008 0 00 00000000 00000040  # sw    r8, 8(r0)
8c0f0008 1 0f 12348001 00000044  # lw    r15, 8(r0)
10220001 0 00 00000000 00000048  # beq   r1, r2, +1 not taken
10840001 0 00 00000000 00000050  # beq   r4, r4, +1 taken
24140bad 1 14 00000bad ffffffff  # skipped
14210001 0 00 00000000 00000054  # bne   r1, r1, +1 not taken
14220002 0 00 00000000 00000060  # bne   r1, r2, +2 taken
24140bad 1 14 00000bad ffffffff  # skipped
24140bad 1 14 00000bad ffffffff  # skipped
0800001a 0 00 00000000 00000068  # j     0x68
24140bad 1 14 00000bad ffffffff  # skipped
0c00001d 1 1f 0000006c 00000074  # jal   0x74
24140bad 1 14 00000bad ffffffff  # skipped
24140bad 1 14 00000bad ffffffff  # skipped
03e08021 1 10 0000006c 00000078  # addu  r16, r31, r0
0800001e 0 00 00000000 00000078  # j     0x78, end of program

/* src.f */
+incdir+rtl
rtl/mips_pkg.sv
rtl/decode.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/branch_unit.sv
rtl/data_mem.sv
rtl/mips_core.sv
verification/tb_mips_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_mips_core -Mdir obj_dir
./obj_dir/Vtb_mips_core | tee sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1
